//--- flist.f
logic/l2w_pkg.sv
logic/l2w_axi_if.sv
logic/l2w_line_if.sv
logic/burst_beat_counter.sv
logic/line_write_buffer.sv
logic/write_arbiter.sv
logic/l2_write_path.sv
tb/l2_write_path_properties.sv
tb/l2_write_path_tb.sv

//--- logic/burst_beat_counter.sv
module burst_beat_counter (
    input  logic                clk,
    input  logic                rstn,
    input  logic                burst_start,
    input  logic                beat_fire,
    output l2w_pkg::beat_idx_t  beat_idx,
    output logic                beat_last
);
    import l2w_pkg::*;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            beat_idx <= '0;
        end else if (burst_start) begin
            beat_idx <= '0;
        end else if (beat_fire) begin
            if (beat_last) begin
                beat_idx <= '0;     // Wrap after the final word
            end else begin
                beat_idx <= beat_idx + 1'b1;
            end
        end
    end

    assign beat_last = (beat_idx == beat_idx_t'(LINE_WORDS - 1));

endmodule

//--- logic/l2_write_path.sv
module l2_write_path (
    input  logic            clk,
    input  logic            rstn,
    // Cache side
    input  l2w_pkg::addr_t  req_addr,
    input  l2w_pkg::line_t  req_line,
    input  logic            req_valid,
    input  logic            req_uncached,
    input  l2w_pkg::strb_t  req_strb,
    output logic            req_ok,
    // AXI write port
    output l2w_pkg::addr_t  awaddr,
    output l2w_pkg::len_t   awlen,
    output logic            awvalid,
    input  logic            awready,
    output l2w_pkg::word_t  wdata,
    output l2w_pkg::strb_t  wstrb,
    output logic            wvalid,
    input  logic            wready,
    output logic            wlast,
    input  logic            bvalid,
    output logic            bready
);

    l2w_line_if line_bus ();
    l2w_axi_if  buf_axi ();

    logic               dma_lock;
    logic               buf_busy;
    l2w_pkg::beat_idx_t beat_idx;
    logic               beat_last;
    logic               beat_fire;
    logic               burst_start;

    write_arbiter arb0 (
        .clk, .rstn,
        .req_addr, .req_line, .req_valid, .req_uncached, .req_strb, .req_ok,
        .line_tx  (line_bus),
        .buf_axi  (buf_axi),
        .awaddr, .awlen, .awvalid, .awready,
        .wdata, .wstrb, .wvalid, .wready, .wlast,
        .bvalid, .bready,
        .buf_busy, .dma_lock
    );

    line_write_buffer lwb0 (
        .clk, .rstn,
        .line_rx  (line_bus),
        .axi      (buf_axi),
        .dma_lock, .buf_busy,
        .beat_idx, .beat_last, .beat_fire, .burst_start
    );

    burst_beat_counter bcnt0 (
        .clk, .rstn,
        .burst_start, .beat_fire,
        .beat_idx, .beat_last
    );

endmodule

//--- logic/l2w_axi_if.sv
interface l2w_axi_if;
    import l2w_pkg::*;

    // Write address channel
    addr_t awaddr;
    len_t  awlen;
    logic  awvalid;
    logic  awready;

    // Write data channel
    word_t wdata;
    strb_t wstrb;
    logic  wvalid;
    logic  wready;
    logic  wlast;

    // Write response channel
    logic  bvalid;
    logic  bready;

    modport master (
        output awaddr, awlen, awvalid, wdata, wstrb, wvalid, wlast, bready,
        input  awready, wready, bvalid
    );

    modport slave (
        input  awaddr, awlen, awvalid, wdata, wstrb, wvalid, wlast, bready,
        output awready, wready, bvalid
    );

endinterface

//--- logic/l2w_line_if.sv
interface l2w_line_if;
    import l2w_pkg::*;

    addr_t addr;
    line_t line;
    logic  req;     // Held until addr_ok
    logic  addr_ok;

    modport src (
        output addr, line, req,
        input  addr_ok
    );

    modport dst (
        input  addr, line, req,
        output addr_ok
    );

endinterface

//--- logic/l2w_pkg.sv
package l2w_pkg;

    // ====================
    // Line geometry
    // ====================
    localparam int OFFSET_WIDTH = 2;
    localparam int LINE_WORDS   = 1 << OFFSET_WIDTH;

    // ====================
    // Width types
    // ====================
    typedef logic [31:0]                addr_t;     // Byte address
    typedef logic [31:0]                word_t;     // One data beat
    typedef logic [LINE_WORDS*32-1:0]   line_t;
    typedef logic [3:0]                 strb_t;
    typedef logic [7:0]                 len_t;      // Beats minus one
    typedef logic [OFFSET_WIDTH-1:0]    beat_idx_t;

    // Burst fields for a whole line
    localparam len_t  LINE_LEN  = len_t'(LINE_WORDS - 1);
    localparam strb_t FULL_STRB = 4'hf;

    // ====================
    // Arbiter FSM
    // ====================
    typedef enum logic [2:0] {
        IDLE,
        BUF_HAND,   // Line hand-off to the buffer
        DIR_AW,
        DIR_W,
        DIR_B
    } arb_state_t;

endpackage

//--- logic/line_write_buffer.sv
module line_write_buffer (
    input  logic                clk,
    input  logic                rstn,
    l2w_line_if.dst             line_rx,
    l2w_axi_if.master           axi,
    input  logic                dma_lock,
    output logic                buf_busy,
    input  l2w_pkg::beat_idx_t  beat_idx,
    input  logic                beat_last,
    output logic                beat_fire,
    output logic                burst_start
);
    import l2w_pkg::*;

    typedef enum logic [1:0] {
        PH_EMPTY,
        PH_AW,
        PH_W,
        PH_B
    } phase_t;

    phase_t phase;
    addr_t  addr_q;
    line_t  line_q;
    logic   accept;

    assign accept = line_rx.req && line_rx.addr_ok;

    // Payload capture
    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q <= line_rx.addr;
            line_q <= line_rx.line;
        end
    end

    // ====================
    // Burst phases
    // ====================
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            phase <= PH_EMPTY;
        end else begin
            case (phase)
                PH_EMPTY: if (accept) phase <= PH_AW;
                PH_AW:    if (burst_start) phase <= PH_W;
                PH_W:     if (beat_fire && beat_last) phase <= PH_B;
                PH_B:     if (axi.bvalid) phase <= PH_EMPTY;
                default:  phase <= PH_EMPTY;
            endcase
        end
    end

    assign line_rx.addr_ok = (phase == PH_EMPTY);
    assign buf_busy        = (phase != PH_EMPTY);

    // Direct writes own the port while locked
    assign axi.awvalid = (phase == PH_AW) && !dma_lock;
    assign axi.awaddr  = addr_q;
    assign axi.awlen   = LINE_LEN;

    assign axi.wvalid  = (phase == PH_W);
    assign axi.wdata   = line_q[beat_idx*$bits(word_t) +: $bits(word_t)];
    assign axi.wstrb   = FULL_STRB;
    assign axi.wlast   = (phase == PH_W) && beat_last;

    assign axi.bready  = (phase == PH_B);

    assign burst_start = axi.awvalid && axi.awready;
    assign beat_fire   = axi.wvalid && axi.wready;

endmodule

//--- logic/write_arbiter.sv
module write_arbiter (
    input  logic            clk,
    input  logic            rstn,
    // Cache side
    input  l2w_pkg::addr_t  req_addr,
    input  l2w_pkg::line_t  req_line,
    input  logic            req_valid,
    input  logic            req_uncached,
    input  l2w_pkg::strb_t  req_strb,
    output logic            req_ok,
    // Line buffer
    l2w_line_if.src         line_tx,
    l2w_axi_if.slave        buf_axi,
    // External AXI write port
    output l2w_pkg::addr_t  awaddr,
    output l2w_pkg::len_t   awlen,
    output logic            awvalid,
    input  logic            awready,
    output l2w_pkg::word_t  wdata,
    output l2w_pkg::strb_t  wstrb,
    output logic            wvalid,
    input  logic            wready,
    output logic            wlast,
    input  logic            bvalid,
    output logic            bready,
    input  logic            buf_busy,
    output logic            dma_lock
);
    import l2w_pkg::*;

    arb_state_t state;
    arb_state_t state_nxt;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // ====================
    // Next state
    // ====================
    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (req_valid && !req_uncached) begin
                    state_nxt = BUF_HAND;
                end else if (req_valid && !buf_busy) begin
                    state_nxt = DIR_AW;   // Uncached waits for the buffer to drain
                end
            end
            BUF_HAND: if (line_tx.addr_ok) state_nxt = IDLE;
            DIR_AW:   if (awready) state_nxt = DIR_W;
            DIR_W:    if (wready) state_nxt = DIR_B;
            DIR_B:    if (bvalid) state_nxt = IDLE;
            default:  state_nxt = IDLE;
        endcase
    end

    assign dma_lock = (state == DIR_AW) || (state == DIR_W) || (state == DIR_B);

    assign line_tx.addr = req_addr;
    assign line_tx.line = req_line;
    assign line_tx.req  = (state == BUF_HAND);

    // ====================
    // AXI port mux
    // ====================
    always_comb begin
        // Buffer owns the port by default
        awaddr          = buf_axi.awaddr;
        awlen           = buf_axi.awlen;
        awvalid         = buf_axi.awvalid;
        wdata           = buf_axi.wdata;
        wstrb           = buf_axi.wstrb;
        wvalid          = buf_axi.wvalid;
        wlast           = buf_axi.wlast;
        bready          = buf_axi.bready;
        buf_axi.awready = awready;
        buf_axi.wready  = wready;
        buf_axi.bvalid  = bvalid;
        req_ok          = 1'b0;

        if (state == BUF_HAND) begin
            req_ok = line_tx.addr_ok;
        end

        if (dma_lock) begin
            awaddr          = req_addr;
            awlen           = '0;                           // Single beat
            awvalid         = (state == DIR_AW);
            wdata           = req_line[$bits(word_t)-1:0];  // Low word only
            wstrb           = req_strb;
            wvalid          = (state == DIR_W);
            wlast           = (state == DIR_W);
            bready          = (state == DIR_B);
            buf_axi.awready = 1'b0;
            buf_axi.wready  = 1'b0;
            buf_axi.bvalid  = 1'b0;
            req_ok          = (state == DIR_B) && bvalid;
        end
    end

endmodule

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f flist.f --top-module l2_write_path_tb -o l2_write_path_sim
./obj_dir/l2_write_path_sim | tee sim.log

if grep -q "^Simulation finished: PASS$" sim.log; then
    exit 0
fi
exit 1

//--- tb/l2_write_path_properties.sv
module l2_write_path_properties (
    input logic            clk,
    input logic            rstn,
    input l2w_pkg::addr_t  awaddr,
    input l2w_pkg::len_t   awlen,
    input logic            awvalid,
    input logic            awready,
    input l2w_pkg::word_t  wdata,
    input l2w_pkg::strb_t  wstrb,
    input logic            wvalid,
    input logic            wready,
    input logic            wlast,
    input logic            bvalid,
    input logic            bready,
    input logic            dma_lock,
    input logic            buf_busy
);

    // ====================
    // Channel handshakes
    // ====================
    aw_hold: assert property (@(posedge clk) disable iff (!rstn)
        awvalid && !awready |=> awvalid && $stable(awaddr) && $stable(awlen))
        else $error("AW valid or payload changed before awready");

    w_hold: assert property (@(posedge clk) disable iff (!rstn)
        wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wstrb) && $stable(wlast))
        else $error("W valid or payload changed before wready");

    b_hold: assert property (@(posedge clk) disable iff (!rstn)
        bready && !bvalid |=> bready)
        else $error("bready dropped before bvalid");

    wlast_ends_burst: assert property (@(posedge clk) disable iff (!rstn)
        wvalid && wready && wlast |=> !wvalid)
        else $error("W beat sent after the beat carrying wlast");

    // Direct writes only start on an empty buffer
    lock_blocks_buf: assert property (@(posedge clk) disable iff (!rstn)
        dma_lock |-> !buf_busy)
        else $error("Buffer held a line during a direct write");

endmodule

bind l2_write_path l2_write_path_properties props0 (
    .clk, .rstn,
    .awaddr, .awlen, .awvalid, .awready,
    .wdata, .wstrb, .wvalid, .wready, .wlast,
    .bvalid, .bready,
    .dma_lock,
    .buf_busy
);

//--- tb/l2_write_path_tb.sv
module l2_write_path_tb;
    import l2w_pkg::*;

    localparam int NUM_REQS    = 200;
    localparam int CYCLE_LIMIT = NUM_REQS * 40;

    logic  clk;
    logic  rstn;
    addr_t req_addr;
    line_t req_line;
    logic  req_valid, req_uncached, req_ok;
    strb_t req_strb;
    addr_t awaddr;
    len_t  awlen;
    word_t wdata;
    strb_t wstrb;
    logic  awvalid, awready, wvalid, wready, wlast, bvalid, bready;

    // Expected transactions in request order
    addr_t exp_addr_q[$];
    len_t  exp_len_q[$];
    line_t exp_line_q[$];
    strb_t exp_strb_q[$];
    logic [7:0] ref_mem [addr_t];
    logic [7:0] obs_mem [addr_t];

    logic [31:0] seed = 32'h1ebd;
    int errors = 0;
    int cycles = 0;
    int issued = 0;
    int done = 0;
    int txns = 0;
    int aw_dly = 0;
    int w_dly = 0;
    int b_dly = 0;
    int beat = 0;
    logic  req_taken = 1'b0;
    logic  b_pend = 1'b0;
    logic  in_burst = 1'b0;
    logic  line_out = 1'b0;    // Line accepted, response not yet seen
    addr_t cur_addr;
    len_t  cur_len;
    line_t cur_line;
    strb_t cur_strb;

    l2_write_path dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: traffic did not drain within %0d cycles", CYCLE_LIMIT);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    function automatic int unsigned rand_below(int unsigned n);
        seed = seed * 32'd1664525 + 32'd1013904223;
        return {16'h0, seed[31:16]} % n;
    endfunction

    function automatic word_t rand_word();
        word_t w;
        w[31:16] = 16'(rand_below(65536));
        w[15:0]  = 16'(rand_below(65536));
        return w;
    endfunction

    // ====================
    // Compare tasks
    // ====================
    task automatic compare_addr(string name, addr_t exp, addr_t got);
        if (exp !== got) begin
            errors++;
            $display("mismatch t=%0t %s exp=%h got=%h", $time, name, exp, got);
        end
    endtask

    task automatic compare_len(string name, len_t exp, len_t got);
        if (exp !== got) begin
            errors++;
            $display("mismatch t=%0t %s exp=%h got=%h", $time, name, exp, got);
        end
    endtask

    task automatic compare_word(string name, word_t exp, word_t got);
        if (exp !== got) begin
            errors++;
            $display("mismatch t=%0t %s exp=%h got=%h", $time, name, exp, got);
        end
    endtask

    task automatic compare_strb(string name, strb_t exp, strb_t got);
        if (exp !== got) begin
            errors++;
            $display("mismatch t=%0t %s exp=%h got=%h", $time, name, exp, got);
        end
    endtask

    task automatic compare_flag(string name, logic exp, logic got);
        if (exp !== got) begin
            errors++;
            $display("mismatch t=%0t %s exp=%b got=%b", $time, name, exp, got);
        end
    endtask

    task automatic compare_byte(string name, logic [7:0] exp, logic [7:0] got);
        if (exp !== got) begin
            errors++;
            $display("mismatch t=%0t %s exp=%h got=%h", $time, name, exp, got);
        end
    endtask

    // ====================
    // Cache driver and model
    // ====================
    task automatic write_ref_mem(addr_t a, line_t d, strb_t s, int words);
        for (int w = 0; w < words; w++) begin
            for (int b = 0; b < 4; b++) begin
                if (s[b]) ref_mem[a + addr_t'(4 * w + b)] = d[w * 32 + b * 8 +: 8];
            end
        end
    endtask

    task automatic new_request();
        addr_t a;
        req_uncached = (rand_below(10) < 4);
        req_strb     = strb_t'(rand_below(15) + 1);
        for (int i = 0; i < LINE_WORDS; i++) begin
            req_line[i * 32 +: 32] = rand_word();
        end
        a = 32'h8000_0000 | (rand_below(64) << 2);     // Small window, lines overlap
        req_addr  = req_uncached ? a : {a[31:4], 4'h0};
        req_valid = 1'b1;
        issued++;
        exp_addr_q.push_back(req_addr);
        exp_len_q.push_back(req_uncached ? len_t'(0) : LINE_LEN);
        exp_line_q.push_back(req_line);
        exp_strb_q.push_back(req_uncached ? req_strb : FULL_STRB);
        write_ref_mem(req_addr, req_line, req_uncached ? req_strb : FULL_STRB,
                      req_uncached ? 1 : LINE_WORDS);
    endtask

    // Sampled mid-cycle, handshakes complete at the next rising edge
    task automatic check_cycle();
        if (req_valid && req_ok) begin
            if (req_uncached) begin
                compare_flag("bvalid at uncached req_ok", 1'b1, bvalid);
                compare_len("awlen of acked write", len_t'(0), cur_len);
            end else begin
                compare_flag("line buffer busy at req_ok", 1'b0, line_out);
                line_out = 1'b1;
            end
            done++;
            req_taken = 1'b1;
        end
        if (wvalid && wready) begin
            if (!in_burst) begin
                errors++;
                $display("W beat at t=%0t arrived outside of any burst", $time);
            end else begin
                compare_word("wdata", cur_line[beat * 32 +: 32], wdata);
                compare_strb("wstrb", cur_strb, wstrb);
                compare_flag("wlast", beat == int'(cur_len), wlast);
                for (int b = 0; b < 4; b++) begin
                    if (wstrb[b]) obs_mem[cur_addr + addr_t'(4 * beat + b)] = wdata[b * 8 +: 8];
                end
                if (beat == int'(cur_len)) begin
                    in_burst = 1'b0;
                    b_pend   = 1'b1;
                    b_dly    = int'(rand_below(4));
                end
                beat++;
            end
            w_dly = int'(rand_below(4));
        end
        if (awvalid && awready) begin
            if (in_burst || b_pend || exp_addr_q.size() == 0) begin
                errors++;
                $display("AW at t=%0t came with no request waiting for it", $time);
            end else begin
                cur_addr = exp_addr_q.pop_front();
                cur_len  = exp_len_q.pop_front();
                cur_line = exp_line_q.pop_front();
                cur_strb = exp_strb_q.pop_front();
                compare_addr("awaddr", cur_addr, awaddr);
                compare_len("awlen", cur_len, awlen);
                if (cur_len == len_t'(0)) compare_flag("line in buffer at direct AW", 1'b0, line_out);
                in_burst = 1'b1;
                beat     = 0;
            end
            aw_dly = int'(rand_below(4));
        end
        if (bvalid && bready) begin
            b_pend = 1'b0;
            if (cur_len == LINE_LEN) line_out = 1'b0;
            txns++;
        end
        if (awvalid && !awready && aw_dly > 0) aw_dly--;
        if (wvalid && !wready && w_dly > 0) w_dly--;
        if (b_pend && !bvalid && b_dly > 0) b_dly--;
    endtask

    task automatic drive_cycle();
        awready = (aw_dly == 0);
        wready  = (w_dly == 0);
        bvalid  = b_pend && (b_dly == 0);
        if (req_taken) begin
            req_taken = 1'b0;
            if (issued < NUM_REQS) new_request();
            else req_valid = 1'b0;
        end
    endtask

    initial begin
        int err0;
        rstn         = 1'b0;
        req_valid    = 1'b0;
        req_uncached = 1'b0;
        req_addr     = '0;
        req_line     = '0;
        req_strb     = '0;
        awready      = 1'b0;
        wready       = 1'b0;
        bvalid       = 1'b0;
        repeat (10) @(posedge clk);
        #1 rstn = 1'b1;

        repeat (5) begin
            @(negedge clk);
            compare_flag("awvalid", 1'b0, awvalid);
            compare_flag("wvalid", 1'b0, wvalid);
            compare_flag("bready", 1'b0, bready);
            compare_flag("req_ok", 1'b0, req_ok);
        end
        $display("test reset_idle: %0d errors", errors);

        err0 = errors;
        @(posedge clk);
        #1 new_request();
        while (!(done == NUM_REQS && exp_addr_q.size() == 0 && !in_burst && !b_pend)) begin
            @(negedge clk);
            check_cycle();
            @(posedge clk);
            #1 drive_cycle();
        end
        if (txns != NUM_REQS) begin
            errors++;
            $display("Saw %0d AXI transactions for %0d requests", txns, NUM_REQS);
        end
        $display("test random_traffic: %0d requests, %0d transactions, %0d errors",
                 done, txns, errors - err0);

        err0 = errors;
        if (ref_mem.size() != obs_mem.size()) begin
            errors++;
            $display("AXI wrote %0d bytes where %0d were expected", obs_mem.size(), ref_mem.size());
        end
        foreach (ref_mem[a]) begin
            if (!obs_mem.exists(a)) begin
                errors++;
                $display("Byte at %h was never written on the AXI port", a);
            end else begin
                compare_byte($sformatf("mem[%h]", a), ref_mem[a], obs_mem[a]);
            end
        end
        $display("test memory_compare: %0d bytes, %0d errors", ref_mem.size(), errors - err0);

        $display("tests 3, requests %0d, transactions %0d, errors %0d", done, txns, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule
